// File: verilog/connCountPkg.sv
package connCountPkg;

    // Graph geometry
    localparam int NODE_COUNT = 16;
    localparam int EDGE_COUNT = NODE_COUNT * (NODE_COUNT - 1) / 2;
    localparam int GRAPH_WIDTH = 128;
    localparam int LABEL_WIDTH = $clog2(NODE_COUNT);

    // 0 to 16 components needs five bits, one spare kept for the output format
    localparam int COUNT_WIDTH = 6;

    // Slot ring
    localparam int SLOT_ADDR_WIDTH = 9;
    localparam int SLOT_COUNT = 1 << SLOT_ADDR_WIDTH;

    // Input FIFO
    localparam int FIFO_DEPTH_LOG2 = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;
    // Four entries of headroom for the upstream to react
    localparam int FIFO_ALMOST_FULL_LEVEL = 12;

    typedef logic [GRAPH_WIDTH-1:0] graphWord;
    typedef logic [SLOT_ADDR_WIDTH-1:0] slotAddr;

    // FIFO payload, graph with the slot it belongs to
    typedef struct packed {
        graphWord graph;
        slotAddr slot;
    } workItem;

    // Counter output toward the collector memory
    typedef struct packed {
        logic [COUNT_WIDTH-1:0] count;
        slotAddr slot;
    } countResult;

endpackage

// File: verilog/slotMemory.sv
`timescale 1ns/1ns

module slotMemory #(
    parameter type payloadType = logic
) (
    input  logic                 clk,
    input  logic                 writeEnable,
    input  connCountPkg::slotAddr writeAddr,
    input  payloadType           writeData,
    input  logic                 readEnable,
    input  connCountPkg::slotAddr readAddr,
    output payloadType           readData
);
    import connCountPkg::*;

    // One entry per ring slot
    payloadType storage [SLOT_COUNT];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[writeAddr] <= writeData;
        end
    end

    // Registered read, holds its last value while disabled
    always_ff @(posedge clk) begin
        if (readEnable) begin
            readData <= storage[readAddr];
        end
    end

endmodule

// File: verilog/inputFifo.sv
`timescale 1ns/1ns

module inputFifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  connCountPkg::workItem pushData,
    output logic                  almostFull,
    output logic                  headValid,
    output connCountPkg::workItem headData,
    input  logic                  pop
);
    import connCountPkg::*;

    workItem buffer [FIFO_DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] writePtr;
    logic [FIFO_DEPTH_LOG2-1:0] readPtr;
    logic [FIFO_DEPTH_LOG2:0] occupancy;
    logic [FIFO_DEPTH_LOG2:0] occupancyNext;

    always_comb begin
        occupancyNext = occupancy;
        if (push && !pop) begin
            occupancyNext = occupancy + 1'b1;
        end else if (pop && !push) begin
            occupancyNext = occupancy - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            occupancy <= '0;
            almostFull <= 1'b0;
        end else begin
            if (push) begin
                writePtr <= writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= readPtr + 1'b1;
            end
            occupancy <= occupancyNext;
            // Rises in the same cycle as the occupancy it reflects
            almostFull <= occupancyNext >= (FIFO_DEPTH_LOG2 + 1)'(FIFO_ALMOST_FULL_LEVEL);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[writePtr] <= pushData;
        end
    end

    // First word falls through, head is visible as soon as it is stored
    assign headValid = occupancy != '0;
    assign headData = buffer[readPtr];

    // Upstream must honor almostFull in time
    assert property (@(posedge clk) disable iff (rst)
        push |-> occupancy != (FIFO_DEPTH_LOG2 + 1)'(FIFO_DEPTH));

    // Consumer only takes a head that exists
    assert property (@(posedge clk) disable iff (rst)
        pop |-> occupancy != '0);

endmodule

// File: verilog/componentCounter.sv
`timescale 1ns/1ns

module componentCounter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     itemValid,
    input  connCountPkg::workItem    item,
    output logic                     ready,
    output logic                     resultWrite,
    output connCountPkg::countResult result
);
    import connCountPkg::*;

    logic busy;
    logic [LABEL_WIDTH:0] iterCount;
    slotAddr currentSlot;

    logic [NODE_COUNT-1:0][NODE_COUNT-1:0] adjacency;
    logic [NODE_COUNT-1:0][NODE_COUNT-1:0] loadAdjacency;
    logic [NODE_COUNT-1:0][LABEL_WIDTH-1:0] label;
    logic [NODE_COUNT-1:0][LABEL_WIDTH-1:0] nextLabel;

    logic [EDGE_COUNT-1:0] edgeBits;
    logic labelChange;
    logic [COUNT_WIDTH-1:0] rootCount;
    logic transfer;

    assign ready = !busy;
    assign transfer = itemValid && ready;
    assign edgeBits = item.graph[EDGE_COUNT-1:0];

    // Row-order edge bits into a symmetric adjacency matrix
    always_comb begin
        loadAdjacency = '0;
        for (int i = 0; i < NODE_COUNT; i++) begin
            for (int j = i + 1; j < NODE_COUNT; j++) begin
                loadAdjacency[i][j] = edgeBits[i * (2 * NODE_COUNT - i - 1) / 2 + j - i - 1];
                loadAdjacency[j][i] = edgeBits[i * (2 * NODE_COUNT - i - 1) / 2 + j - i - 1];
            end
        end
    end

    // Each node takes the smallest label among itself and its neighbors
    always_comb begin
        for (int n = 0; n < NODE_COUNT; n++) begin
            nextLabel[n] = label[n];
            for (int m = 0; m < NODE_COUNT; m++) begin
                if (adjacency[n][m] && label[m] < nextLabel[n]) begin
                    nextLabel[n] = label[m];
                end
            end
        end
    end

    assign labelChange = nextLabel != label;

    // A component root keeps its own index as label
    always_comb begin
        rootCount = '0;
        for (int n = 0; n < NODE_COUNT; n++) begin
            if (label[n] == LABEL_WIDTH'(n)) begin
                rootCount = rootCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            iterCount <= '0;
        end else if (transfer) begin
            busy <= 1'b1;
            iterCount <= '0;
        end else if (busy) begin
            if (labelChange) begin
                iterCount <= iterCount + 1'b1;
            end else begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            adjacency <= loadAdjacency;
            currentSlot <= item.slot;
            for (int n = 0; n < NODE_COUNT; n++) begin
                label[n] <= LABEL_WIDTH'(n);
            end
        end else if (busy) begin
            label <= nextLabel;
        end
    end

    // Converged on the first round without change
    assign resultWrite = busy && !labelChange;
    assign result.count = rootCount;
    assign result.slot = currentSlot;

    // Labels settle within the graph diameter
    assert property (@(posedge clk) disable iff (rst)
        busy |-> iterCount <= (LABEL_WIDTH + 1)'(NODE_COUNT));

endmodule

// File: verilog/streamingCountConnectedCore.sv
`timescale 1ns/1ns

module streamingCountConnectedCore #(
    parameter int EXTRA_DATA_WIDTH = 1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 botValid,
    input  connCountPkg::graphWord                graphIn,
    input  logic [EXTRA_DATA_WIDTH-1:0]          extraDataIn,
    input  logic                                 freezeCore,
    output logic                                 almostFull,
    output logic                                 resultValid,
    output logic [connCountPkg::COUNT_WIDTH-1:0] connectCount,
    output logic [EXTRA_DATA_WIDTH-1:0]          extraDataOut
);
    import connCountPkg::*;

    typedef struct packed {
        logic valid;
        logic [EXTRA_DATA_WIDTH-1:0] extraData;
    } validEntry;

    slotAddr ringSlot;
    slotAddr ringSlotDelayed;
    logic ringPrimed;

    logic botValidDelayed;
    logic [EXTRA_DATA_WIDTH-1:0] extraDataDelayed;

    workItem pushItem;
    workItem headItem;
    logic headValid;
    logic counterReady;
    logic resultWrite;
    countResult counterResult;

    logic [COUNT_WIDTH-1:0] collectorRead;
    validEntry validWrite;
    validEntry validRead;
    logic readFrozen;
    logic readPrimed;

    // Ring advances on every unfrozen cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ringSlot <= '0;
            ringSlotDelayed <= '0;
            botValidDelayed <= 1'b0;
            ringPrimed <= 1'b0;
        end else if (!freezeCore) begin
            ringSlot <= ringSlot + 1'b1;
            ringSlotDelayed <= ringSlot;
            botValidDelayed <= botValid;
            // First pass reads slots not yet written since reset
            if (ringSlot == slotAddr'(SLOT_COUNT - 1)) begin
                ringPrimed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freezeCore) begin
            extraDataDelayed <= extraDataIn;
        end
    end

    assign pushItem.graph = graphIn;
    assign pushItem.slot = ringSlot;

    inputFifo workFifo (
        .clk(clk),
        .rst(rst),
        .push(botValid),
        .pushData(pushItem),
        .almostFull(almostFull),
        .headValid(headValid),
        .headData(headItem),
        .pop(headValid && counterReady)
    );

    componentCounter countEngine (
        .clk(clk),
        .rst(rst),
        .itemValid(headValid),
        .item(headItem),
        .ready(counterReady),
        .resultWrite(resultWrite),
        .result(counterResult)
    );

    slotMemory #(
        .payloadType(logic [COUNT_WIDTH-1:0])
    ) collectorMemory (
        .clk(clk),
        .writeEnable(resultWrite),
        .writeAddr(counterResult.slot),
        .writeData(counterResult.count),
        .readEnable(!freezeCore),
        .readAddr(ringSlot),
        .readData(collectorRead)
    );

    // Written every unfrozen cycle, so empty slots record valid 0
    assign validWrite.valid = botValidDelayed;
    assign validWrite.extraData = extraDataDelayed;

    slotMemory #(
        .payloadType(validEntry)
    ) validMemory (
        .clk(clk),
        .writeEnable(!freezeCore),
        .writeAddr(ringSlotDelayed),
        .writeData(validWrite),
        .readEnable(!freezeCore),
        .readAddr(ringSlot),
        .readData(validRead)
    );

    // Output register, a frozen read never shows as valid
    always_ff @(posedge clk) begin
        if (rst) begin
            readFrozen <= 1'b0;
            readPrimed <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            readFrozen <= freezeCore;
            if (!freezeCore) begin
                readPrimed <= ringPrimed;
            end
            resultValid <= validRead.valid && readPrimed && !readFrozen;
        end
    end

    always_ff @(posedge clk) begin
        connectCount <= collectorRead;
        extraDataOut <= validRead.extraData;
    end

    // Upstream holds off while the ring is frozen
    assert property (@(posedge clk) disable iff (rst)
        freezeCore |-> !botValid);

endmodule

// File: verif/tbStreamingCountConnectedCore.sv
`timescale 1ns/1ns

module tbStreamingCountConnectedCore;
    import connCountPkg::*;

    localparam int EXTRA_WIDTH = 8;
    localparam int TEST_COUNT = 5;
    localparam int GRAPH_TOTAL = 4 + 200 + 8 + 40 + 16;
    // Up to 18 cycles per graph, a ring pass with margin per test, sparse gaps
    localparam int WATCHDOG_CYCLES = GRAPH_TOTAL * (NODE_COUNT + 2)
        + TEST_COUNT * (SLOT_COUNT + 100) + 8 * 64;

    typedef struct packed {
        logic valid;
        logic [31:0] due;
        logic [COUNT_WIDTH-1:0] count;
        logic [EXTRA_WIDTH-1:0] extra;
        logic [2:0] testId;
    } expectedResult;

    logic clk;
    logic rst;
    logic botValid;
    graphWord graphIn;
    logic [EXTRA_WIDTH-1:0] extraDataIn;
    logic freezeCore;
    logic almostFull;
    logic resultValid;
    logic [COUNT_WIDTH-1:0] connectCount;
    logic [EXTRA_WIDTH-1:0] extraDataOut;

    int seed = 32'h285a;
    int unfrozenCount;
    int currentTest;
    int errorCount;
    int resultsSeen [TEST_COUNT];
    int testErrors [TEST_COUNT];
    string testNames [TEST_COUNT] = '{"fixedGraphs", "randomGraphs", "emptySlots",
                                      "backPressure", "freeze"};
    expectedResult pending [$];
    expectedResult stageOne;
    expectedResult stageTwo;

    streamingCountConnectedCore #(
        .EXTRA_DATA_WIDTH(EXTRA_WIDTH)
    ) i_streamingCountConnectedCore (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Union-find over the row-order edge bits, upper bits ignored
    function automatic int countComponents(input graphWord g);
        int parent [NODE_COUNT];
        int k;
        int a;
        int b;
        int roots;
        k = 0;
        roots = 0;
        for (int n = 0; n < NODE_COUNT; n++) begin
            parent[n] = n;
        end
        for (int i = 0; i < NODE_COUNT; i++) begin
            for (int j = i + 1; j < NODE_COUNT; j++) begin
                if (g[k]) begin
                    a = i;
                    b = j;
                    while (parent[a] != a) begin
                        a = parent[a];
                    end
                    while (parent[b] != b) begin
                        b = parent[b];
                    end
                    parent[a] = b;
                end
                k++;
            end
        end
        for (int n = 0; n < NODE_COUNT; n++) begin
            roots += (parent[n] == n);
        end
        return roots;
    endfunction

    // Shape 0 is the chain 0-1-...-15, shape 1 two cliques on nodes 0-4 and 6-10
    function automatic graphWord shapeGraph(input int shape);
        graphWord g;
        int k;
        g = '0;
        k = 0;
        for (int i = 0; i < NODE_COUNT; i++) begin
            for (int j = i + 1; j < NODE_COUNT; j++) begin
                if (shape == 0) begin
                    g[k] = (j == i + 1);
                end else begin
                    g[k] = (j <= 4) || (i >= 6 && j <= 10);
                end
                k++;
            end
        end
        return g;
    endfunction

    // Density out of 256 per edge bit
    function automatic graphWord randomGraph(input int density);
        graphWord g;
        for (int k = 0; k < GRAPH_WIDTH; k++) begin
            g[k] = ($random(seed) & 255) < density;
        end
        return g;
    endfunction

    // Holds off while the FIFO is almost full
    task automatic sendGraph(input graphWord g);
        @(posedge clk);
        while (almostFull) begin
            botValid <= 1'b0;
            @(posedge clk);
        end
        botValid <= 1'b1;
        freezeCore <= 1'b0;
        graphIn <= g;
        extraDataIn <= EXTRA_WIDTH'($random(seed));
    endtask

    task automatic holdCycles(input int cycles, input logic freeze);
        repeat (cycles) begin
            @(posedge clk);
            botValid <= 1'b0;
            freezeCore <= freeze;
        end
    endtask

    task automatic finishTest();
        holdCycles(2, 1'b0);
        while (pending.size() != 0 || stageOne.valid || stageTwo.valid) begin
            holdCycles(1, 1'b0);
        end
        holdCycles(3, 1'b0);
        $display("%s: %0d results checked, %0d errors", testNames[currentTest],
                 resultsSeen[currentTest], testErrors[currentTest]);
    endtask

    task automatic countError(input int testId);
        errorCount++;
        testErrors[testId]++;
    endtask

    // A result is read SLOT_COUNT unfrozen cycles after its input,
    // then passes the memory read and the output register
    always @(posedge clk) begin
        expectedResult entry;
        if (rst) begin
            unfrozenCount = 0;
            stageOne <= '0;
            stageTwo <= '0;
        end else begin
            if (!freezeCore) begin
                unfrozenCount = unfrozenCount + 1;
            end
            stageTwo <= stageOne;
            stageOne <= '0;
            if (pending.size() != 0 && pending[0].due == 32'(unfrozenCount)) begin
                entry = pending.pop_front();
                entry.valid = 1'b1;
                stageOne <= entry;
                resultsSeen[entry.testId]++;
            end
            if (botValid) begin
                entry.valid = 1'b0;
                entry.due = 32'(unfrozenCount + SLOT_COUNT);
                entry.count = COUNT_WIDTH'(countComponents(graphIn));
                entry.extra = extraDataIn;
                entry.testId = 3'(currentTest);
                pending.push_back(entry);
            end
        end
    end

    resultOnTime: assert property (@(posedge clk) disable iff (rst)
        stageTwo.valid |-> resultValid)
        else begin
            $display("FAIL %s: expected resultValid 1, got %0b",
                     testNames[$sampled(stageTwo.testId)], $sampled(resultValid));
            countError($sampled(stageTwo.testId));
        end

    resultValue: assert property (@(posedge clk) disable iff (rst)
        stageTwo.valid && resultValid |->
            connectCount == stageTwo.count && extraDataOut == stageTwo.extra)
        else begin
            $display("FAIL %s: expected count %0d extra %02h, got count %0d extra %02h",
                     testNames[$sampled(stageTwo.testId)], $sampled(stageTwo.count),
                     $sampled(stageTwo.extra), $sampled(connectCount),
                     $sampled(extraDataOut));
            countError($sampled(stageTwo.testId));
        end

    // Slots without input and frozen reads never show a result
    quietSlot: assert property (@(posedge clk) disable iff (rst)
        !stageTwo.valid |-> !resultValid)
        else begin
            $display("FAIL %s: expected resultValid 0, got 1", testNames[currentTest]);
            countError(currentTest);
        end

    resetState: assert property (@(posedge clk) $fell(rst) |-> !almostFull && !resultValid)
        else begin
            $display("FAIL reset: expected almostFull 0 resultValid 0, got %0b %0b",
                     $sampled(almostFull), $sampled(resultValid));
            errorCount++;
        end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("Watchdog expired after %0d cycles with %0d results outstanding",
                 WATCHDOG_CYCLES, pending.size());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int totalResults;
        rst = 1'b1;
        botValid = 1'b0;
        freezeCore = 1'b0;
        graphIn = '0;
        extraDataIn = '0;
        errorCount = 0;
        totalResults = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Runs inside the first ring pass, so every early output must stay quiet
        currentTest = 0;
        sendGraph('0);
        sendGraph({8'h5a, {EDGE_COUNT{1'b1}}});
        sendGraph(shapeGraph(0));
        sendGraph(shapeGraph(1));
        finishTest();

        currentTest = 1;
        for (int n = 0; n < 200; n++) begin
            sendGraph(randomGraph(($random(seed) & 255) >> ($random(seed) & 3)));
        end
        finishTest();

        currentTest = 2;
        for (int n = 0; n < 8; n++) begin
            sendGraph(randomGraph(24));
            holdCycles(20 + ($random(seed) & 31), 1'b0);
        end
        finishTest();

        // Dense graphs arrive faster than the counter drains them
        currentTest = 3;
        for (int n = 0; n < 40; n++) begin
            sendGraph(randomGraph(230));
        end
        finishTest();

        currentTest = 4;
        for (int n = 0; n < 4; n++) begin
            for (int g = 0; g < 4; g++) begin
                sendGraph(randomGraph(40));
            end
            holdCycles(5, 1'b0);
            holdCycles(2 + 3 * n, 1'b1);
        end
        // Freeze again while the results come back around
        holdCycles(490, 1'b0);
        for (int n = 0; n < 6; n++) begin
            holdCycles(n + 1, 1'b1);
            holdCycles(4, 1'b0);
        end
        finishTest();

        for (int t = 0; t < TEST_COUNT; t++) begin
            totalResults += resultsSeen[t];
        end
        $display("Summary: %0d tests, %0d results checked, %0d errors",
                 TEST_COUNT, totalResults, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/connCountPkg.sv
verilog/slotMemory.sv
verilog/inputFifo.sv
verilog/componentCounter.sv
verilog/streamingCountConnectedCore.sv
verif/tbStreamingCountConnectedCore.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbStreamingCountConnectedCore
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
